// ==== common/sine_table.hex ====
// one sine period, 64 samples, one 20-bit two's complement value per line
00000
0C8BD
18F8B
25280
30FBC
3C56B
471CE
5133C
5A827
62F1F
6A6D9
70E2C
7641A
7A7CF
7D8A5
7F622
7FFFF
7F622
7D8A5
7A7CF
7641A
70E2C
6A6D9
62F1F
5A827
5133C
471CE
3C56B
30FBC
25280
18F8B
0C8BD
00000
F3743
E7075
DAD80
CF044
C3A95
B8E32
AECC4
A57D9
9D0E1
95927
8F1D4
89BE6
85831
8275B
809DE
80001
809DE
8275B
85831
89BE6
8F1D4
95927
9D0E1
A57D9
AECC4
B8E32
C3A95
CF044
DAD80
E7075
F3743

// ==== audio_codec_top.f ====
common/audio_pkg.sv
source/debounce.sv
source/volume_control.sv
ac97/ac97_frame.sv
ac97/ac97_commands.sv
source/playback_sample.sv
source/audio_codec_top.sv
bench/codec_model.sv
bench/audio_codec_tb.sv

// ==== Makefile ====
TOP = audio_codec_tb

sim:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module $(TOP) -f audio_codec_top.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== bench/audio_codec_tb.sv ====
`timescale 1ns/1ps

module audio_codec_tb;
  import audio_pkg::*;

  localparam int FRAMES         = 40;
  localparam int HOLD_CYCLES    = 24;
  localparam int TIMEOUT_CYCLES = 16 + CODEC_RESET_CYCLES + 42 * FRAME_BITS;

  logic       clock;
  logic       reset;
  logic       volume_up;
  logic       volume_down;
  logic       tone_enable;
  pcm8_t      audio_out_data;
  pcm8_t      audio_in_data;
  logic       frame_ready;
  logic       audio_reset_b;
  logic       ac97_synch;
  logic       ac97_sdata_out;
  logic       ac97_sdata_in;
  // codec model side
  sample_t    capture_word;
  logic       frame_done;
  logic [15:0] frame_tag;
  codec_cmd_t frame_command;
  sample_t    frame_left;
  sample_t    frame_right;
  logic       pad_zero;
  pcm8_t      capture_byte;

  logic [31:0] rng_state;
  sample_t     sine_table [SINE_STEPS];
  // predictions, one per frame_ready
  codec_cmd_t  expected_commands [$];
  sample_t     expected_samples [$];

  audio_codec_top #(.stable_cycles(16)) dut (
    .clock          (clock),
    .reset          (reset),
    .volume_up      (volume_up),
    .volume_down    (volume_down),
    .tone_enable    (tone_enable),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .frame_ready    (frame_ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in)
  );

  codec_model codec (
    .clock          (clock),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .capture_word   (capture_word),
    .frame_done     (frame_done),
    .tag            (frame_tag),
    .command        (frame_command),
    .left           (frame_left),
    .right          (frame_right),
    .pad_zero       (pad_zero),
    .capture_byte   (capture_byte)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic abort_run(string reason);
    $display("SOME TESTS FAILED");
    $fatal(1, reason);
  endtask

  task automatic check_command(string name, codec_cmd_t got, codec_cmd_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, want);
      abort_run("stopped at the first mismatch");
    end
  endtask

  task automatic check_sample(string name, sample_t got, sample_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, want);
      abort_run("stopped at the first mismatch");
    end
  endtask

  task automatic check_pcm(string name, pcm8_t got, pcm8_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, want);
      abort_run("stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(string name, logic got, logic want);
    if (got !== want) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, want);
      abort_run("stopped at the first mismatch");
    end
  endtask

  task automatic check_count(string name, int got, int want);
    if (got != want) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, want);
      abort_run("stopped at the first mismatch");
    end
  endtask

  // codec setup table, one entry per sequencer step
  function automatic codec_cmd_t expected_command(int step, volume_t level);
    logic [7:0]  address;
    logic [15:0] data;
    volume_t     att;
    att     = volume_t'(VOLUME_MAX - int'(level));
    address = REG_READ_ID;
    data    = 16'h0000;
    case (step)
      3: begin
        address = REG_HEADPHONE;
        data    = {3'b000, att, 3'b000, att};
      end
      5: begin
        address = REG_PCM;
        data    = 16'h0808;
      end
      6: begin
        address = REG_RECORD_SELECT;
        data    = {3'b000, volume_t'(RECORD_SOURCE_MIC), 3'b000, volume_t'(RECORD_SOURCE_MIC)};
      end
      7: begin
        address = REG_RECORD_GAIN;
        data    = 16'h0F0F;
      end
      9: begin
        address = REG_MIC;
        data    = 16'h8048;
      end
      10: address = REG_BEEP;
      11: begin
        address = REG_GENERAL;
        data    = 16'h8000;
      end
      default: ;
    endcase
    return {address, data};
  endfunction

  // what the DUT latches at this frame_ready
  function automatic sample_t expected_sample(int index);
    pcm8_t top;
    if (tone_enable)
      top = sine_table[index][SLOT_BITS-1 -: 8];
    else
      top = audio_out_data;
    return {top, {(SLOT_BITS - 8){1'b0}}};
  endfunction

  // saturating step, both buttons cancel
  function automatic volume_t next_volume(volume_t level, logic up, logic down);
    if (up && !down && level != volume_t'(VOLUME_MAX))
      return level + 1'b1;
    if (down && !up && level != '0)
      return level - 1'b1;
    return level;
  endfunction

  task automatic check_frame(int index);
    codec_cmd_t want_command;
    sample_t    want_sample;
    logic       valid;
    valid        = index > 0;
    want_command = '0;
    want_sample  = '0;
    if (valid) begin
      if (expected_commands.size() == 0)
        abort_run("a frame arrived with no frame_ready before it");
      want_command = expected_commands.pop_front();
      want_sample  = expected_samples.pop_front();
    end
    check_bit("tag frame valid", frame_tag[15], 1'b1);
    check_bit("tag command address valid", frame_tag[14], valid);
    check_bit("tag command data valid", frame_tag[13], valid);
    check_bit("tag left valid", frame_tag[12], 1'b1);
    check_bit("tag right valid", frame_tag[11], 1'b1);
    check_bit("frame padding zero", pad_zero, 1'b1);
    check_command("slot 1/2 command", frame_command, want_command);
    check_sample("slot 3 left", frame_left, want_sample);
    check_sample("slot 4 right", frame_right, want_sample);
    // capture byte of the frame just ended
    check_pcm("audio_in_data", audio_in_data, capture_byte);
  endtask

  //////////////////////////////
  // main sequence and checks
  //////////////////////////////
  initial begin
    int frame;
    rng_state      = 32'd73;
    reset          = 1'b1;
    volume_up      = 1'b0;
    volume_down    = 1'b0;
    tone_enable    = 1'b0;
    audio_out_data = '0;
    capture_word   = sample_t'(next_random());
    $readmemh(SINE_FILE, sine_table);
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (frame = 0; frame < FRAMES; frame++) begin
      @(negedge clock);
      while (frame_done !== 1'b1)
        @(negedge clock);
      capture_word <= sample_t'(next_random());
      check_frame(frame);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // one update per frame, then up to three button presses
  initial begin
    int          ready_count;
    int          press;
    volume_t     model_volume;
    logic [31:0] r;
    logic        up;
    logic        down;
    logic        dominant_up;
    ready_count  = 0;
    model_volume = volume_t'(VOLUME_RESET);
    @(negedge clock);
    while (reset)
      @(negedge clock);
    forever begin
      while (frame_ready !== 1'b1)
        @(negedge clock);
      expected_commands.push_back(expected_command(ready_count % COMMAND_STEPS, model_volume));
      expected_samples.push_back(expected_sample(ready_count % SINE_STEPS));
      ready_count++;
      @(posedge clock);
      r = next_random();
      tone_enable    <= r[0];
      audio_out_data <= r[15:8];
      // mostly down early to hit 0, mostly up later to hit 31
      dominant_up = ready_count > 12;
      for (press = 0; press < 3; press++) begin
        r = next_random();
        case (r[2:0])
          3'd0: begin
            up   = 1'b1;
            down = 1'b1;
          end
          3'd1: begin
            up   = !dominant_up;
            down = dominant_up;
          end
          default: begin
            up   = dominant_up;
            down = !dominant_up;
          end
        endcase
        volume_up   <= up;
        volume_down <= down;
        repeat (HOLD_CYCLES) @(posedge clock);
        volume_up   <= 1'b0;
        volume_down <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clock);
        model_volume = next_volume(model_volume, up, down);
      end
      @(negedge clock);
    end
  end

  // codec reset length and frame marker timing
  initial begin
    int   low_cycles;
    int   frame_pos;
    logic running;
    low_cycles = 0;
    frame_pos  = 0;
    running    = 1'b0;
    forever begin
      @(negedge clock);
      if (!reset && !running) begin
        if (!audio_reset_b) begin
          low_cycles++;
          check_bit("ac97_synch", ac97_synch, 1'b0);
          check_bit("ac97_sdata_out", ac97_sdata_out, 1'b0);
          check_bit("frame_ready", frame_ready, 1'b0);
        end else begin
          check_count("codec reset cycles", low_cycles, CODEC_RESET_CYCLES);
          running = 1'b1;
        end
      end
      if (running) begin
        check_bit("audio_reset_b", audio_reset_b, 1'b1);
        check_bit("ac97_synch", ac97_synch, frame_pos < SYNCH_BITS);
        check_bit("frame_ready", frame_ready, frame_pos == READY_BIT);
        frame_pos = (frame_pos + 1) % FRAME_BITS;
      end
    end
  end

  // cycle limit
  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: the frames did not finish within %0d cycles", TIMEOUT_CYCLES);
        abort_run("run stopped by the cycle limit");
      end
    end
  end

endmodule

// ==== bench/codec_model.sv ====
`timescale 1ns/1ps

module codec_model (
  input  logic                  clock,
  input  logic                  ac97_synch,
  input  logic                  ac97_sdata_out,
  output logic                  ac97_sdata_in,
  input  audio_pkg::sample_t    capture_word,
  output logic                  frame_done,
  output logic [15:0]           tag,
  output audio_pkg::codec_cmd_t command,
  output audio_pkg::sample_t    left,
  output audio_pkg::sample_t    right,
  output logic                  pad_zero,
  output audio_pkg::pcm8_t      capture_byte
);
  import audio_pkg::*;

  localparam int TOP        = FRAME_BITS - 1;
  localparam int CAPTURE_LO = SLOT_START[3];
  // tag plus four slots
  localparam int HEAD_BITS  = SLOT_START[4] + SLOT_BITS;

  // frame bit k lands at index TOP-k
  logic [FRAME_BITS-1:0] bits;
  sample_t               slot1;
  sample_t               slot2;
  // capture word of the frame in flight
  sample_t               frame_capture;
  logic                  synch_last;
  logic                  started;
  logic                  next_bit;
  int                    pos;

  assign slot1 = bits[TOP - SLOT_START[1] -: SLOT_BITS];
  assign slot2 = bits[TOP - SLOT_START[2] -: SLOT_BITS];

  //////////////////////////////
  // frame decode, mid-cycle
  //////////////////////////////
  initial begin
    bits          = '0;
    synch_last    = 1'b0;
    started       = 1'b0;
    next_bit      = 1'b0;
    pos           = 0;
    frame_capture = '0;
    frame_done    = 1'b0;
    tag           = '0;
    command       = '0;
    left          = '0;
    right         = '0;
    pad_zero      = 1'b0;
    capture_byte  = '0;
    forever begin
      @(negedge clock);
      frame_done <= 1'b0;
      // synch rise marks frame bit 0
      if (ac97_synch && !synch_last) begin
        started       = 1'b1;
        pos           = 0;
        frame_capture = capture_word;
      end else begin
        pos = pos + 1;
      end
      synch_last = ac97_synch;
      if (started && pos < FRAME_BITS)
        bits[TOP - pos] = ac97_sdata_out;
      // last bit in, hand the fields over
      if (started && pos == TOP) begin
        frame_done   <= 1'b1;
        tag          <= bits[TOP -: 16];
        command      <= {slot1[SLOT_BITS-1 -: 8], slot2[SLOT_BITS-1 -: 16]};
        left         <= bits[TOP - SLOT_START[3] -: SLOT_BITS];
        right        <= bits[TOP - SLOT_START[4] -: SLOT_BITS];
        pad_zero     <= bits[TOP - 5 -: 11] == '0 && slot1[11:0] == '0 &&
                        slot2[3:0] == '0 && bits[TOP - HEAD_BITS:0] == '0;
        capture_byte <= frame_capture[SLOT_BITS-1 -: 8];
      end
      // slot 3 bit for the coming cycle
      next_bit = 1'b0;
      if (started && pos + 1 >= CAPTURE_LO && pos + 1 < CAPTURE_LO + SLOT_BITS)
        next_bit = frame_capture[SLOT_BITS - 1 - (pos + 1 - CAPTURE_LO)];
    end
  end

  // capture data toward the DUT
  initial begin
    ac97_sdata_in = 1'b0;
    forever begin
      @(posedge clock);
      ac97_sdata_in <= next_bit;
    end
  end

endmodule

// ==== source/audio_codec_top.sv ====
`timescale 1ns/1ps

module audio_codec_top #(
  parameter int stable_cycles = audio_pkg::DEBOUNCE_CYCLES
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             volume_up,
  input  logic             volume_down,
  input  logic             tone_enable,
  input  audio_pkg::pcm8_t audio_out_data,
  output audio_pkg::pcm8_t audio_in_data,
  output logic             frame_ready,
  // codec pins
  output logic             audio_reset_b,
  output logic             ac97_synch,
  output logic             ac97_sdata_out,
  input  logic             ac97_sdata_in
);
  import audio_pkg::*;

  volume_t    volume;
  codec_cmd_t command;
  logic       command_valid;
  sample_t    play_sample;

  volume_control #(.stable_cycles(stable_cycles)) volume_ctrl (
    .clock       (clock),
    .reset       (reset),
    .volume_up   (volume_up),
    .volume_down (volume_down),
    .volume      (volume)
  );

  // setup writes, one per frame
  ac97_commands commands (
    .clock         (clock),
    .reset         (reset),
    .frame_ready   (frame_ready),
    .volume        (volume),
    .command       (command),
    .command_valid (command_valid)
  );

  playback_sample playback (
    .clock          (clock),
    .reset          (reset),
    .frame_ready    (frame_ready),
    .tone_enable    (tone_enable),
    .audio_out_data (audio_out_data),
    .play_sample    (play_sample)
  );

  ac97_frame frame (
    .clock          (clock),
    .reset          (reset),
    .command        (command),
    .command_valid  (command_valid),
    .play_sample    (play_sample),
    .frame_ready    (frame_ready),
    .audio_in_data  (audio_in_data),
    .audio_reset_b  (audio_reset_b),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in)
  );

endmodule

// ==== source/playback_sample.sv ====
`timescale 1ns/1ps

module playback_sample (
  input  logic               clock,
  input  logic               reset,
  input  logic               frame_ready,
  input  logic               tone_enable,
  input  audio_pkg::pcm8_t   audio_out_data,
  output audio_pkg::sample_t play_sample
);
  import audio_pkg::*;

  localparam int INDEX_BITS = $clog2(SINE_STEPS);
  localparam int PAD_BITS   = SLOT_BITS - $bits(pcm8_t);

  // one sine period in 20-bit signed samples
  sample_t                sine_table [SINE_STEPS];
  logic [INDEX_BITS-1:0]  tone_index;

  initial $readmemh(SINE_FILE, sine_table);

  // index steps once per frame, sample taken on the same pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      tone_index  <= '0;
      play_sample <= '0;
    end else if (frame_ready) begin
      tone_index <= tone_index + 1'b1;
      // only the top 8 bits of the tone, same as user data
      if (tone_enable)
        play_sample <= {sine_table[tone_index][SLOT_BITS-1 -: $bits(pcm8_t)], {PAD_BITS{1'b0}}};
      else
        play_sample <= {audio_out_data, {PAD_BITS{1'b0}}};
    end
  end

endmodule

// ==== ac97/ac97_commands.sv ====
`timescale 1ns/1ps

module ac97_commands (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  frame_ready,
  input  audio_pkg::volume_t    volume,
  output audio_pkg::codec_cmd_t command,
  output logic                  command_valid
);
  import audio_pkg::*;

  localparam int STATE_BITS = $clog2(COMMAND_STEPS);

  logic [STATE_BITS-1:0] state;
  codec_cmd_t            next_command;
  // codec wants attenuation rather than gain
  volume_t               attenuation;

  assign attenuation = volume_t'(VOLUME_MAX) - volume;

  //////////////////////////////
  // register table
  //////////////////////////////
  always_comb begin
    // read ID unless the state says otherwise
    next_command = '0;
    next_command.reg_view.address = REG_READ_ID;
    case (state)
      3: begin
        next_command.level_view.address     = REG_HEADPHONE;
        next_command.level_view.left_level  = attenuation;
        next_command.level_view.right_level = attenuation;
      end
      5: next_command.reg_view = '{address: REG_PCM, data: 16'h0808};
      6: begin
        // mic on both sides
        next_command.level_view.address     = REG_RECORD_SELECT;
        next_command.level_view.left_level  = volume_t'(RECORD_SOURCE_MIC);
        next_command.level_view.right_level = volume_t'(RECORD_SOURCE_MIC);
      end
      7: next_command.reg_view = '{address: REG_RECORD_GAIN, data: 16'h0F0F};
      // +20 dB mic boost
      9: next_command.reg_view = '{address: REG_MIC, data: 16'h8048};
      10: next_command.reg_view = '{address: REG_BEEP, data: 16'h0000};
      // pcm out bypasses 3D
      11: next_command.reg_view = '{address: REG_GENERAL, data: 16'h8000};
      default: ;
    endcase
  end

  // one step per frame
  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= '0;
      command_valid <= 1'b0;
    end else if (frame_ready) begin
      state         <= (state == STATE_BITS'(COMMAND_STEPS - 1)) ? '0 : state + 1'b1;
      command_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (frame_ready)
      command <= next_command;
  end

  // once running, valid stays up with a defined command word
  a_valid_holds: assert property (@(posedge clock) disable iff (reset)
    command_valid |=> command_valid && !$isunknown(command));

endmodule

// ==== ac97/ac97_frame.sv ====
`timescale 1ns/1ps

module ac97_frame (
  input  logic                  clock,
  input  logic                  reset,
  input  audio_pkg::codec_cmd_t command,
  input  logic                  command_valid,
  input  audio_pkg::sample_t    play_sample,
  output logic                  frame_ready,
  output audio_pkg::pcm8_t      audio_in_data,
  output logic                  audio_reset_b,
  output logic                  ac97_synch,
  output logic                  ac97_sdata_out,
  input  logic                  ac97_sdata_in
);
  import audio_pkg::*;

  localparam int TAG_BITS   = SLOT_START[1];
  localparam int CAPTURE_LO = SLOT_START[3];
  localparam int CAPTURE_HI = SLOT_START[4];
  // tag plus four slots, everything after is zero
  localparam int HEAD_BITS  = SLOT_START[4] + SLOT_BITS;
  localparam int COUNT_BITS = $clog2(FRAME_BITS);
  localparam int DELAY_BITS = $clog2(CODEC_RESET_CYCLES);

  logic [DELAY_BITS-1:0] delay_count;
  logic [COUNT_BITS-1:0] bit_count;
  logic                  last_bit;
  logic                  in_capture;
  // slot contents held for the whole frame
  codec_cmd_t            command_l;
  logic                  command_valid_l;
  sample_t               sample_l;
  sample_t               capture;
  logic [TAG_BITS-1:0]   tag;
  logic [HEAD_BITS-1:0]  frame_head;

  //////////////////////////////
  // codec reset delay
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      delay_count   <= '0;
      audio_reset_b <= 1'b0;
    end else if (!audio_reset_b) begin
      if (delay_count == DELAY_BITS'(CODEC_RESET_CYCLES - 1))
        audio_reset_b <= 1'b1;
      else
        delay_count <= delay_count + 1'b1;
    end
  end

  // frame counter, wraps by itself at 256
  always_ff @(posedge clock) begin
    if (reset)
      bit_count <= '0;
    else if (audio_reset_b)
      bit_count <= bit_count + 1'b1;
  end

  assign last_bit    = audio_reset_b && bit_count == COUNT_BITS'(FRAME_BITS - 1);
  assign frame_ready = audio_reset_b && bit_count == COUNT_BITS'(READY_BIT);
  assign ac97_synch  = audio_reset_b && bit_count < COUNT_BITS'(SYNCH_BITS);
  assign in_capture  = audio_reset_b && bit_count >= COUNT_BITS'(CAPTURE_LO) &&
                       bit_count < COUNT_BITS'(CAPTURE_HI);

  // next frame's data, taken on the last bit
  // first frame after the delay goes out empty
  always_ff @(posedge clock) begin
    if (reset) begin
      command_l       <= '0;
      command_valid_l <= 1'b0;
      sample_l        <= '0;
      audio_in_data   <= '0;
    end else if (last_bit) begin
      command_l       <= command_valid ? command : '0;
      command_valid_l <= command_valid;
      sample_l        <= play_sample;
      audio_in_data   <= capture[SLOT_BITS-1 -: $bits(pcm8_t)];
    end
  end

  // slot 3 in, MSB first
  always_ff @(posedge clock) begin
    if (in_capture)
      capture <= {capture[SLOT_BITS-2:0], ac97_sdata_in};
  end

  //////////////////////////////
  // serializer
  //////////////////////////////

  // frame valid, cmd addr, cmd data, left, right
  assign tag = {1'b1, command_valid_l, command_valid_l, 1'b1, 1'b1, {(TAG_BITS - 5){1'b0}}};

  // address and data are left justified in their slots
  assign frame_head = {tag,
                       command_l.reg_view.address, {(SLOT_BITS - 8){1'b0}},
                       command_l.reg_view.data, {(SLOT_BITS - 16){1'b0}},
                       sample_l,
                       sample_l};

  always_comb begin
    ac97_sdata_out = 1'b0;
    if (audio_reset_b && bit_count < COUNT_BITS'(HEAD_BITS))
      ac97_sdata_out = frame_head[HEAD_BITS - 1 - int'(bit_count)];
  end

  // marker lasts exactly the tag slot every frame
  a_synch_width: assert property (@(posedge clock) disable iff (reset)
    $rose(ac97_synch) |-> ac97_synch [*SYNCH_BITS] ##1 !ac97_synch);

endmodule

// ==== source/volume_control.sv ====
`timescale 1ns/1ps

module volume_control #(
  parameter int stable_cycles = audio_pkg::DEBOUNCE_CYCLES
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               volume_up,
  input  logic               volume_down,
  output audio_pkg::volume_t volume
);
  import audio_pkg::*;

  logic up_clean;
  logic down_clean;
  // previous debounced levels for edge detect
  logic up_last;
  logic down_last;
  logic up_edge;
  logic down_edge;

  debounce #(.stable_cycles(stable_cycles)) up_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (volume_up),
    .clean (up_clean)
  );

  debounce #(.stable_cycles(stable_cycles)) down_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (volume_down),
    .clean (down_clean)
  );

  assign up_edge   = up_clean & ~up_last;
  assign down_edge = down_clean & ~down_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      // a button held through reset is not a press
      up_last   <= 1'b1;
      down_last <= 1'b1;
      volume    <= volume_t'(VOLUME_RESET);
    end else begin
      up_last   <= up_clean;
      down_last <= down_clean;
      // both at once cancel out
      if (up_edge && !down_edge && volume != volume_t'(VOLUME_MAX))
        volume <= volume + 1'b1;
      else if (down_edge && !up_edge && volume != '0)
        volume <= volume - 1'b1;
    end
  end

  // at most one step per cycle and no wrap at either end
  a_volume_step: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> (volume == $past(volume)) ||
      ({1'b0, volume} == {1'b0, $past(volume)} + 6'd1) ||
      ({1'b0, volume} + 6'd1 == {1'b0, $past(volume)}));

endmodule

// ==== source/debounce.sv ====
`timescale 1ns/1ps

module debounce #(
  parameter int stable_cycles = audio_pkg::DEBOUNCE_CYCLES
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // wide enough to reach stable_cycles
  localparam int COUNT_BITS = $clog2(stable_cycles + 1);

  logic [COUNT_BITS-1:0] count;
  // last level seen on the input
  logic                  sampled;

  always_ff @(posedge clock) begin
    if (reset) begin
      count   <= '0;
      sampled <= noisy;
      clean   <= noisy;
    end else if (noisy != sampled) begin
      // input moved, start counting again
      sampled <= noisy;
      count   <= '0;
    end else if (count == COUNT_BITS'(stable_cycles)) begin
      // held long enough, pass it on
      clean <= sampled;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== common/audio_pkg.sv ====
package audio_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  // one bit per clock, 256 bits per frame
  localparam int FRAME_BITS = 256;
  // synch high for the tag slot only
  localparam int SYNCH_BITS = 16;
  // mid-frame point for the ready pulse
  localparam int READY_BIT  = 128;
  localparam int SLOT_BITS  = 20;
  // first bit of tag, cmd address, cmd data, left, right
  localparam int SLOT_START [5] = '{0, 16, 36, 56, 76};

  // codec held in reset this long
  localparam int CODEC_RESET_CYCLES = 1024;

  //////////////////////////////
  // user controls
  //////////////////////////////

  // about 10 ms at 27 MHz
  localparam int DEBOUNCE_CYCLES = 270000;
  localparam int VOLUME_RESET    = 8;
  localparam int VOLUME_MAX      = 31;

  // tone table
  localparam int    SINE_STEPS = 64;
  localparam string SINE_FILE  = "common/sine_table.hex";

  //////////////////////////////
  // codec registers
  //////////////////////////////

  // record source select code for the mic input
  localparam int RECORD_SOURCE_MIC = 0;
  // sequencer wraps after this many frames
  localparam int COMMAND_STEPS     = 16;

  localparam logic [7:0] REG_READ_ID       = 8'h80;
  localparam logic [7:0] REG_HEADPHONE     = 8'h04;
  localparam logic [7:0] REG_PCM           = 8'h18;
  localparam logic [7:0] REG_RECORD_SELECT = 8'h1A;
  localparam logic [7:0] REG_RECORD_GAIN   = 8'h1C;
  localparam logic [7:0] REG_MIC           = 8'h0E;
  localparam logic [7:0] REG_BEEP          = 8'h0A;
  localparam logic [7:0] REG_GENERAL       = 8'h20;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [SLOT_BITS-1:0] sample_t;
  typedef logic [4:0]           volume_t;
  typedef logic [7:0]           pcm8_t;

  // one command word, two views of the 16 data bits
  typedef union packed {
    struct packed {
      logic [7:0]  address;
      logic [15:0] data;
    } reg_view;
    // per-side level fields, used for attenuation and record source
    struct packed {
      logic [7:0] address;
      logic [2:0] left_pad;
      volume_t    left_level;
      logic [2:0] right_pad;
      volume_t    right_level;
    } level_view;
  } codec_cmd_t;

endpackage
